// File: src/u2_pkg.sv
////////////////////////////////////////////////////////////
// Shared types, settings address map and readback indices
// for the board core. Imported by every design unit
////////////////////////////////////////////////////////////

package u2_pkg;

   ////////////////////////////////////////////////////////////
   // Widths that carry a meaning
   typedef logic [7:0]  set_addr_t;   // Settings register address
   typedef logic [31:0] set_data_t;   // Settings data word
   typedef logic [31:0] secs_t;       // VITA seconds
   typedef logic [31:0] ticks_t;      // VITA ticks within the second
   typedef logic [2:0]  rb_addr_t;    // Readback word select
   typedef logic [31:0] rb_word_t;    // Readback data
   typedef logic [7:0]  led_t;        // LED vector

   ////////////////////////////////////////////////////////////
   // Settings bus address map
   localparam set_addr_t SR_CLOCK_CTRL  = 8'd0;
   localparam set_addr_t SR_SERDES_CTRL = 8'd1;
   localparam set_addr_t SR_ADC_CTRL    = 8'd2;
   localparam set_addr_t SR_LED_SW      = 8'd3;
   localparam set_addr_t SR_PHY_RESET   = 8'd4;
   localparam set_addr_t SR_LED_SRC     = 8'd8;

   // Time block, three words: seconds, ticks (commits), immediate flag
   localparam set_addr_t SR_TIME64      = 8'd192;

   // 1 selects the hardware bit, 0 the software bit
   localparam led_t LED_SRC_AT_RESET = 8'b0001_1110;

   // Bump when the register map changes
   localparam rb_word_t COMPAT_NUM = 32'd4;

   localparam int unsigned TICKS_PER_SEC_DEFAULT = 100_000_000;

   ////////////////////////////////////////////////////////////
   // Readback word indices, anything else reads zero
   localparam rb_addr_t RB_STATUS     = 3'd0;
   localparam rb_addr_t RB_COMPAT     = 3'd1;
   localparam rb_addr_t RB_TIME_SECS  = 3'd2;
   localparam rb_addr_t RB_TIME_TICKS = 3'd3;
   localparam rb_addr_t RB_PPS_SECS   = 3'd4;
   localparam rb_addr_t RB_PPS_TICKS  = 3'd5;

endpackage

// File: src/vita_time_if.sv
////////////////////////////////////////////////////////////
// VITA time bundle from the timekeeper to its consumers:
// live time, PPS-latched time and the per-PPS pulse
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface vita_time_if import u2_pkg::*; ();

   secs_t  time_secs;    // Live time
   ticks_t time_ticks;
   secs_t  pps_secs;     // Time captured at the last PPS edge
   ticks_t pps_ticks;
   logic   pps_pulse;    // One cycle per PPS edge

   modport keeper (
      output time_secs,
      output time_ticks,
      output pps_secs,
      output pps_ticks,
      output pps_pulse
   );

   modport reader (
      input time_secs,
      input time_ticks,
      input pps_secs,
      input pps_ticks,
      input pps_pulse
   );

endinterface

// File: src/setting_bank.sv
////////////////////////////////////////////////////////////
// Control register bank on the settings bus. Each register
// loads on a strobe at its own address and drives board pins
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module setting_bank import u2_pkg::*; (
   input  logic      dsp_clk,
   input  logic      wb_rst,

   // Settings write port
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,

   // Clock gen control
   output logic [1:0] clk_en_o,
   output logic [1:0] clk_sel_o,
   output logic      clock_ready_o,

   // SERDES control
   output logic      ser_enable_o,
   output logic      ser_prbsen_o,
   output logic      ser_loopen_o,
   output logic      ser_rx_en_o,

   // ADC control
   output logic      adc_oe_a_o,
   output logic      adc_on_a_o,
   output logic      adc_oe_b_o,
   output logic      adc_on_b_o,

   output logic      phy_reset_n_o,   // Active low at the pin
   output led_t      led_sw_o,
   output led_t      led_src_o
);

   logic [4:0] clock_r;    // {ready, en[1:0], sel[1:0]}
   logic [3:0] serdes_r;   // {enable, prbsen, loopen, rx_en}
   logic [3:0] adc_r;      // {oe_a, on_a, oe_b, on_b}
   logic       phy_rst_r;
   led_t       led_sw_r;
   led_t       led_src_r;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         clock_r   <= '0;
         serdes_r  <= '0;
         adc_r     <= '0;
         phy_rst_r <= 1'b0;
         led_sw_r  <= '0;
         led_src_r <= LED_SRC_AT_RESET;
      end else if (set_stb_i) begin
         case (set_addr_i)
            SR_CLOCK_CTRL:  clock_r   <= set_data_i[4:0];
            SR_SERDES_CTRL: serdes_r  <= set_data_i[3:0];
            SR_ADC_CTRL:    adc_r     <= set_data_i[3:0];
            SR_LED_SW:      led_sw_r  <= set_data_i[7:0];
            SR_PHY_RESET:   phy_rst_r <= set_data_i[0];
            SR_LED_SRC:     led_src_r <= set_data_i[7:0];
            default: ;                  // Not ours, time block decodes its own
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Split the words into control lines
   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_r;
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_r;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_r;

   assign phy_reset_n_o = ~phy_rst_r;
   assign led_sw_o      = led_sw_r;
   assign led_src_o     = led_src_r;

endmodule

// File: src/vita_time_keeper.sv
////////////////////////////////////////////////////////////
// 64-bit VITA timekeeper. Counts ticks into seconds, loads
// from the settings bus now or at PPS, latches time per PPS
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vita_time_keeper import u2_pkg::*; #(
   parameter int unsigned TICKS_PER_SEC = TICKS_PER_SEC_DEFAULT
) (
   input  logic      dsp_clk,
   input  logic      wb_rst,

   // Settings write port
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,

   input  logic      pps_i,      // Asynchronous PPS from the board
   vita_time_if.keeper vt
);

   secs_t  secs_stage;           // Staged load value
   ticks_t ticks_stage;
   logic   imm_flag;             // 1 = load on the ticks write itself
   logic   armed;                // Load waiting for the next PPS edge

   secs_t  time_secs;
   ticks_t time_ticks;
   secs_t  pps_secs;
   ticks_t pps_ticks;

   logic   pps_sync1;
   logic   pps_sync2;
   logic   pps_del;
   logic   pps_edge;

   logic   ticks_wr;
   logic   load_now;
   logic   pps_load;
   logic   last_tick;

   ////////////////////////////////////////////////////////////
   // Settings decode for the three time words
   assign ticks_wr = set_stb_i && (set_addr_i == SR_TIME64 + 8'd1);
   assign load_now = ticks_wr && imm_flag;
   assign pps_load = pps_edge && armed;

   always_ff @(posedge dsp_clk) begin
      if (set_stb_i && (set_addr_i == SR_TIME64))
         secs_stage <= set_data_i;
      if (ticks_wr)
         ticks_stage <= set_data_i;
   end

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         imm_flag <= 1'b0;
         armed    <= 1'b0;
      end else begin
         if (set_stb_i && (set_addr_i == SR_TIME64 + 8'd2))
            imm_flag <= set_data_i[0];
         if (ticks_wr)
            armed <= ~imm_flag;   // Immediate load cancels any pending one
         else if (pps_edge)
            armed <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // PPS synchroniser and rising edge detect
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         pps_sync1 <= 1'b0;
         pps_sync2 <= 1'b0;
         pps_del   <= 1'b0;
      end else begin
         pps_sync1 <= pps_i;
         pps_sync2 <= pps_sync1;
         pps_del   <= pps_sync2;
      end
   end

   assign pps_edge = pps_sync2 & ~pps_del;

   ////////////////////////////////////////////////////////////
   // Time counter
   assign last_tick = (time_ticks == ticks_t'(TICKS_PER_SEC - 1));

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         time_secs  <= '0;
         time_ticks <= '0;
      end else if (load_now) begin
         time_secs  <= secs_stage;
         time_ticks <= set_data_i;     // Ticks word arrives with the commit
      end else if (pps_load) begin
         time_secs  <= secs_stage;
         time_ticks <= ticks_stage;
      end else if (last_tick) begin
         time_secs  <= time_secs + 1'b1;
         time_ticks <= '0;
      end else begin
         time_ticks <= time_ticks + 1'b1;
      end
   end

   // Snapshot on each PPS edge, the new value if a load fires there
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         pps_secs  <= '0;
         pps_ticks <= '0;
      end else if (pps_edge) begin
         pps_secs  <= pps_load ? secs_stage  : time_secs;
         pps_ticks <= pps_load ? ticks_stage : time_ticks;
      end
   end

   assign vt.time_secs  = time_secs;
   assign vt.time_ticks = time_ticks;
   assign vt.pps_secs   = pps_secs;
   assign vt.pps_ticks  = pps_ticks;
   assign vt.pps_pulse  = pps_edge;

endmodule

// File: src/status_readback.sv
////////////////////////////////////////////////////////////
// Registered readback mux for status and time, plus the
// LED mix of hardware and software bits and the PPS interrupt
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module status_readback import u2_pkg::*; (
   input  logic     dsp_clk,
   input  logic     wb_rst,

   input  rb_addr_t rb_addr_i,

   // Hardware status
   input  logic     clk_status_i,
   input  logic     serdes_link_up_i,
   input  logic     run_rx_i,
   input  logic     run_tx_i,

   input  led_t     led_sw_i,
   input  led_t     led_src_i,    // 1 = hardware drives that LED
   vita_time_if.reader vt,

   output rb_word_t rb_data_o,
   output led_t     leds_o,
   output logic     pps_int_o
);

   logic [3:0] hw_bits;
   rb_word_t   status_word;
   led_t       led_hw;

   assign hw_bits     = {run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i};
   assign status_word = {28'd0, hw_bits};
   assign led_hw      = {3'b000, hw_bits, 1'b0};   // Bit 0 has no hardware source

   ////////////////////////////////////////////////////////////
   // Readback mux
   always_ff @(posedge dsp_clk) begin
      case (rb_addr_i)
         RB_STATUS:     rb_data_o <= status_word;
         RB_COMPAT:     rb_data_o <= COMPAT_NUM;
         RB_TIME_SECS:  rb_data_o <= vt.time_secs;
         RB_TIME_TICKS: rb_data_o <= vt.time_ticks;
         RB_PPS_SECS:   rb_data_o <= vt.pps_secs;
         RB_PPS_TICKS:  rb_data_o <= vt.pps_ticks;
         default:       rb_data_o <= '0;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // LEDs and PPS interrupt
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         leds_o    <= '0;
         pps_int_o <= 1'b0;
      end else begin
         leds_o    <= (led_src_i & led_hw) | (~led_src_i & led_sw_i);
         pps_int_o <= vt.pps_pulse;
      end
   end

endmodule

// File: src/u2_core.sv
////////////////////////////////////////////////////////////
// Board core top level on dsp_clk: settings registers,
// VITA timekeeper and status readback
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module u2_core import u2_pkg::*; #(
   parameter int unsigned TICKS_PER_SEC = TICKS_PER_SEC_DEFAULT
) (
   input  logic       dsp_clk,
   input  logic       wb_rst,

   // Settings bus
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,

   input  logic       pps_i,
   input  rb_addr_t   rb_addr_i,

   // Hardware status
   input  logic       clk_status_i,
   input  logic       serdes_link_up_i,
   input  logic       run_rx_i,
   input  logic       run_tx_i,

   // Board control pins
   output logic [1:0] clk_en_o,
   output logic [1:0] clk_sel_o,
   output logic       clock_ready_o,
   output logic       ser_enable_o,
   output logic       ser_prbsen_o,
   output logic       ser_loopen_o,
   output logic       ser_rx_en_o,
   output logic       adc_oe_a_o,
   output logic       adc_on_a_o,
   output logic       adc_oe_b_o,
   output logic       adc_on_b_o,
   output logic       phy_reset_n_o,

   output rb_word_t   rb_data_o,
   output led_t       leds_o,
   output logic       pps_int_o
);

   led_t led_sw;
   led_t led_src;

   vita_time_if vt_if ();

   setting_bank u_setting_bank (
      .dsp_clk          (dsp_clk),
      .wb_rst           (wb_rst),
      .set_stb_i        (set_stb_i),
      .set_addr_i       (set_addr_i),
      .set_data_i       (set_data_i),
      .clk_en_o         (clk_en_o),
      .clk_sel_o        (clk_sel_o),
      .clock_ready_o    (clock_ready_o),
      .ser_enable_o     (ser_enable_o),
      .ser_prbsen_o     (ser_prbsen_o),
      .ser_loopen_o     (ser_loopen_o),
      .ser_rx_en_o      (ser_rx_en_o),
      .adc_oe_a_o       (adc_oe_a_o),
      .adc_on_a_o       (adc_on_a_o),
      .adc_oe_b_o       (adc_oe_b_o),
      .adc_on_b_o       (adc_on_b_o),
      .phy_reset_n_o    (phy_reset_n_o),
      .led_sw_o         (led_sw),
      .led_src_o        (led_src)
   );

   vita_time_keeper #(
      .TICKS_PER_SEC    (TICKS_PER_SEC)
   ) u_vita_time_keeper (
      .dsp_clk          (dsp_clk),
      .wb_rst           (wb_rst),
      .set_stb_i        (set_stb_i),
      .set_addr_i       (set_addr_i),
      .set_data_i       (set_data_i),
      .pps_i            (pps_i),
      .vt               (vt_if.keeper)
   );

   status_readback u_status_readback (
      .dsp_clk          (dsp_clk),
      .wb_rst           (wb_rst),
      .rb_addr_i        (rb_addr_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .run_rx_i         (run_rx_i),
      .run_tx_i         (run_tx_i),
      .led_sw_i         (led_sw),
      .led_src_i        (led_src),
      .vt               (vt_if.reader),
      .rb_data_o        (rb_data_o),
      .leds_o           (leds_o),
      .pps_int_o        (pps_int_o)
   );

endmodule

// File: verif/tb_u2_core.sv
////////////////////////////////////////////////////////////
// Testbench for the board core: random settings writes,
// LED mix, VITA time loads and readback against a model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_u2_core import u2_pkg::*; ();

   logic       dsp_clk;
   logic       wb_rst;
   logic       set_stb_i;
   set_addr_t  set_addr_i;
   set_data_t  set_data_i;
   logic       pps_i;
   rb_addr_t   rb_addr_i;
   logic       clk_status_i;
   logic       serdes_link_up_i;
   logic       run_rx_i;
   logic       run_tx_i;
   logic [1:0] clk_en_o;
   logic [1:0] clk_sel_o;
   logic       clock_ready_o;
   logic       ser_enable_o;
   logic       ser_prbsen_o;
   logic       ser_loopen_o;
   logic       ser_rx_en_o;
   logic       adc_oe_a_o;
   logic       adc_on_a_o;
   logic       adc_oe_b_o;
   logic       adc_on_b_o;
   logic       phy_reset_n_o;
   rb_word_t   rb_data_o;
   led_t       leds_o;
   logic       pps_int_o;

   int unsigned errors;
   int unsigned checks;
   logic [31:0] lcg_state;

   // Register model
   logic [4:0] clock_m;    // {ready, en, sel}
   logic [3:0] serdes_m;
   logic [3:0] adc_m;
   logic       phy_m;
   led_t       led_sw_m;
   led_t       led_src_m;

   u2_core #(.TICKS_PER_SEC(1000)) UUT (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .pps_i(pps_i), .rb_addr_i(rb_addr_i),
      .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .run_rx_i(run_rx_i), .run_tx_i(run_tx_i),
      .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o), .clock_ready_o(clock_ready_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_reset_n_o(phy_reset_n_o),
      .rb_data_o(rb_data_o), .leds_o(leds_o), .pps_int_o(pps_int_o)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #10 dsp_clk = ~dsp_clk;
   end

   // Guard against a hung run
   initial begin
      #1_000_000;
      $display("Simulation ran past its time limit");
      $display("** FAIL **");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Helpers

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [31:0] control_expect();
      return {18'd0, ~phy_m, adc_m, serdes_m, clock_m};
   endfunction

   function automatic logic [31:0] control_actual();
      return {18'd0, phy_reset_n_o, adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o,
              ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o,
              clock_ready_o, clk_en_o, clk_sel_o};
   endfunction

   // Set mask bits pick the hardware bits shifted up by one
   function automatic led_t led_expect();
      led_t hw;
      led_t mixed;
      hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};
      for (int i = 0; i < 8; i++)
         mixed[i] = led_src_m[i] ? hw[i] : led_sw_m[i];
      return mixed;
   endfunction

   task automatic next_cycle();
      @(posedge dsp_clk);
      #2;                      // Drive and sample clear of the edge
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("ERR %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      next_cycle();
      set_stb_i  = 1'b0;
      case (addr)
         SR_CLOCK_CTRL:  clock_m   = data[4:0];
         SR_SERDES_CTRL: serdes_m  = data[3:0];
         SR_ADC_CTRL:    adc_m     = data[3:0];
         SR_LED_SW:      led_sw_m  = data[7:0];
         SR_PHY_RESET:   phy_m     = data[0];
         SR_LED_SRC:     led_src_m = data[7:0];
         default: ;
      endcase
   endtask

   task automatic read_word(input rb_addr_t idx, output rb_word_t data);
      rb_addr_i = idx;
      next_cycle();
      data = rb_data_o;
   endtask

   task automatic drive_hw_bits();
      logic [31:0] r;
      r = lcg_next();
      {run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i} = r[7:4];
   endtask

   task automatic wait_pps_int(output bit seen);
      seen = 1'b0;
      for (int i = 0; i < 20 && !seen; i++) begin
         next_cycle();
         seen = pps_int_o;
      end
      if (!seen) begin
         errors++;
         $display("No PPS interrupt within 20 cycles of the PPS edge");
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   initial begin : main
      rb_word_t    rd;
      secs_t       secs_val;
      ticks_t      ticks_val;
      logic [31:0] r;
      int unsigned gap;
      int unsigned pulses;
      bit          seen;

      errors = 0;
      checks = 0;
      lcg_state = 32'hb041;
      wb_rst = 1'b1;
      set_stb_i = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      pps_i = 1'b0;
      rb_addr_i = RB_TIME_TICKS;
      {run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i} = 4'b0000;
      clock_m = '0;
      serdes_m = '0;
      adc_m = '0;
      phy_m = 1'b0;
      led_sw_m = '0;
      led_src_m = LED_SRC_AT_RESET;

      // 1. Reset values with ticks held at zero in reset
      repeat (10) @(posedge dsp_clk);
      #2;
      check_value("reset ticks", 32'd0, rb_data_o);
      wb_rst = 1'b0;
      check_value("reset control", control_expect(), control_actual());
      read_word(RB_TIME_SECS, rd);
      check_value("reset secs", 32'd0, rd);
      read_word(RB_PPS_SECS, rd);
      check_value("reset pps secs", 32'd0, rd);
      read_word(RB_PPS_TICKS, rd);
      check_value("reset pps ticks", 32'd0, rd);

      // LED source mask still at its reset value
      drive_hw_bits();
      write_setting(SR_LED_SW, lcg_next());
      next_cycle();
      check_value("reset leds", 32'(led_expect()), 32'(leds_o));

      // 2. Random settings writes over the low 16 addresses
      repeat (40) begin
         r = lcg_next();
         write_setting(set_addr_t'(r[11:8]), lcg_next());
         next_cycle();
         check_value("settings", control_expect(), control_actual());
      end

      // 3. LED mix
      repeat (20) begin
         drive_hw_bits();
         write_setting(SR_LED_SW, lcg_next());
         write_setting(SR_LED_SRC, lcg_next());
         next_cycle();
         check_value("leds", 32'(led_expect()), 32'(leds_o));
      end

      // 4. Immediate time load
      repeat (5) begin
         secs_val = lcg_next();
         ticks_val = lcg_next() % 900;
         write_setting(SR_TIME64 + 8'd2, 32'd1);
         write_setting(SR_TIME64, secs_val);
         write_setting(SR_TIME64 + 8'd1, ticks_val);
         read_word(RB_TIME_TICKS, rd);
         checks++;
         assert (rd >= ticks_val && rd <= ticks_val + 32'd20) else begin
            errors++;
            $display("ERR imm ticks: expected %0d..%0d, actual %0d",
                     ticks_val, ticks_val + 32'd20, rd);
         end
         read_word(RB_TIME_SECS, rd);
         check_value("imm secs", secs_val, rd);
      end

      // 5. Load armed for PPS with ticks close to rollover
      repeat (3) begin
         secs_val = lcg_next();
         write_setting(SR_TIME64 + 8'd2, 32'd0);
         write_setting(SR_TIME64, secs_val);
         write_setting(SR_TIME64 + 8'd1, 32'd990);
         gap = (lcg_next() % 16) + 1;
         repeat (gap) next_cycle();
         pps_i = 1'b1;
         wait_pps_int(seen);
         pulses = seen ? 1 : 0;
         repeat (10) begin
            next_cycle();
            if (pps_int_o)
               pulses++;
         end
         check_value("pps pulse count", 32'd1, pulses);
         pps_i = 1'b0;
         read_word(RB_PPS_SECS, rd);
         check_value("pps secs", secs_val, rd);
         read_word(RB_PPS_TICKS, rd);
         check_value("pps ticks", 32'd990, rd);
         repeat (30) next_cycle();
         read_word(RB_TIME_SECS, rd);
         check_value("rollover secs", secs_val + 32'd1, rd);
      end

      // 6. Readback constants and status
      repeat (4) begin
         drive_hw_bits();
         read_word(RB_STATUS, rd);
         check_value("status", {28'd0, run_tx_i, run_rx_i, clk_status_i,
                     serdes_link_up_i}, rd);
      end
      read_word(RB_COMPAT, rd);
      check_value("compat", COMPAT_NUM, rd);
      read_word(3'd6, rd);
      check_value("index 6", 32'd0, rd);
      read_word(3'd7, rd);
      check_value("index 7", 32'd0, rd);

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// File: src.f
src/u2_pkg.sv
src/vita_time_if.sv
src/setting_bank.sv
src/vita_time_keeper.sv
src/status_readback.sv
src/u2_core.sv
verif/tb_u2_core.sv

// File: run_sim.sh
#!/bin/sh
# Build the board core testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_u2_core -f src.f -o tb_u2_core
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/tb_u2_core)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qF '** PASS **'; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
